// File: alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// operand and result width, 8, 16 or 32.
`define ALU_DATA_WIDTH 16

// number of lanes in the cluster.
`define ALU_NUM_LANES 4

// request tag width.
`define ALU_TAG_WIDTH 4

`endif

// File: alu_pkg.sv
`default_nettype none
`include "alu_defs.svh"

package alu_pkg;

   typedef logic signed [`ALU_DATA_WIDTH-1:0] data_t;
   typedef logic [`ALU_TAG_WIDTH-1:0]         tag_t;
   typedef logic [`ALU_NUM_LANES-1:0]         lane_mask_t;

   typedef enum logic [1:0] {
      OP_ADD,
      OP_SUB,
      OP_MUL,
      OP_DIV
   } op_e;

   // lane FSM, one adder shared by every state.
   typedef enum logic [2:0] {
      IDLE,
      SIGN_B,
      SIGN_Q,
      MUL,
      DIV_R,
      DIV_CMP,
      DIV_CNT
   } lane_state_e;

   typedef struct packed {
      op_e   op;
      tag_t  tag;
      data_t a;
      data_t b;
   } alu_req_t;

   typedef struct packed {
      tag_t  tag;
      data_t q;
      logic  ovf;
      logic  zero;
   } alu_rsp_t;

endpackage

`default_nettype wire

// File: sat_adder.sv
`default_nettype none
`timescale 1ns/100ps
`include "alu_defs.svh"

module sat_adder
   import alu_pkg::*;
(
   input  wire data_t i_a,
   input  wire data_t i_b,
   output data_t      o_q,
   output logic       o_ovf
);

   localparam int MSB = `ALU_DATA_WIDTH - 1;

   assign o_q   = i_a + i_b;   // wraps.

   // same operand signs but the sum flipped.
   assign o_ovf = (i_a[MSB] == i_b[MSB]) && (o_q[MSB] != i_a[MSB]);

endmodule

`default_nettype wire

// File: seq_alu.sv
`default_nettype none
`timescale 1ns/100ps
`include "alu_defs.svh"

module seq_alu
   import alu_pkg::*;
(
   input  wire           i_clk,
   input  wire           i_nrst,
   input  wire           i_start,
   input  wire alu_req_t i_req,
   output logic          o_done,
   output alu_rsp_t      o_rsp
);

   localparam int    W     = `ALU_DATA_WIDTH;
   localparam int    MSB   = W - 1;
   localparam int    CNT_W = $clog2(W);
   localparam data_t ONE   = data_t'(1);
   localparam data_t MIN   = {1'b1, {(W-1){1'b0}}};

   lane_state_e      state;
   lane_state_e      state_nxt;
   data_t            a;            // multiplier or dividend magnitude.
   data_t            b;            // multiplicand or divisor magnitude.
   data_t            r;            // partial remainder.
   data_t            q;            // accumulator and quotient.
   logic [CNT_W-1:0] cnt;
   logic             neg;
   logic             is_mul;
   tag_t             tag_r;
   logic             ovf_r;
   logic             zero_r;
   logic             fin;
   logic             fin_ovf;
   logic             fin_zero;
   data_t            add_a;
   data_t            add_b;
   data_t            add_q;
   logic             add_ovf;
   logic             a_neg;
   logic             b_neg;
   logic             a_min;
   logic             b_min;
   logic             div_zero;
   logic             sub_ovf;
   logic             mul_ovf;
   logic             a_last;
   logic             cnt_last;
   logic             q_bit;
   lane_state_e      run_state;

   assign a_neg     = i_req.a[MSB];
   assign b_neg     = i_req.b[MSB];
   assign a_min     = (i_req.a == MIN);
   assign b_min     = (i_req.b == MIN);
   assign div_zero  = (i_req.op == OP_DIV) && (i_req.b == '0);
   assign sub_ovf   = (i_req.a[MSB] ^ i_req.b[MSB]) & (add_q[MSB] ^ i_req.a[MSB]);
   assign mul_ovf   = b[MSB] | (a[0] & add_ovf);   // shifted out or sum wrapped.
   assign a_last    = (a[MSB:1] == '0);
   assign cnt_last  = (cnt == CNT_W'(W - 1));
   assign q_bit     = ~add_q[MSB];                  // remainder stayed positive.
   assign run_state = (i_req.op == OP_MUL) ? MUL : DIV_R;

   // operand steering for the shared adder.
   always_comb begin
      add_a = i_req.a;
      add_b = i_req.b;
      case (state)
         IDLE: begin
            case (i_req.op)
               OP_ADD: ;
               OP_SUB: add_b = -i_req.b;
               default: begin
                  add_a = a_neg ? ~i_req.a : ~i_req.b;   // invert, then add one.
                  add_b = ONE;
               end
            endcase
         end
         SIGN_B: begin
            add_a = ~b;
            add_b = ONE;
         end
         SIGN_Q: begin
            add_a = ~q;
            add_b = ONE;
         end
         MUL: begin
            add_a = q;
            add_b = b;
         end
         DIV_CMP: begin
            add_a = r;
            add_b = -b;
         end
         DIV_CNT: begin
            add_a = data_t'(cnt);
            add_b = ONE;
         end
         default: ;
      endcase
   end

   sat_adder adder_inst (
      .i_a   (add_a),
      .i_b   (add_b),
      .o_q   (add_q),
      .o_ovf (add_ovf)
   );

   always_comb begin
      state_nxt = state;
      fin       = 1'b0;
      fin_ovf   = 1'b0;
      fin_zero  = 1'b0;
      case (state)
         IDLE: begin
            if (i_start) begin
               if (i_req.op == OP_ADD) begin
                  fin     = 1'b1;
                  fin_ovf = add_ovf;
               end else if (i_req.op == OP_SUB) begin
                  fin     = 1'b1;
                  fin_ovf = sub_ovf;
               end else if (div_zero) begin
                  fin      = 1'b1;
                  fin_ovf  = 1'b1;
                  fin_zero = 1'b1;
               end else if (a_min | b_min) begin
                  fin     = 1'b1;
                  fin_ovf = 1'b1;
               end else begin
                  state_nxt = (a_neg & b_neg) ? SIGN_B : run_state;
               end
            end
         end
         SIGN_B:  state_nxt = is_mul ? MUL : DIV_R;
         SIGN_Q: begin
            fin       = 1'b1;
            state_nxt = IDLE;
         end
         MUL: begin
            if (mul_ovf) begin
               fin       = 1'b1;
               fin_ovf   = 1'b1;
               state_nxt = IDLE;
            end else if (a_last) begin
               fin       = ~neg;
               state_nxt = neg ? SIGN_Q : IDLE;
            end
         end
         DIV_R:   state_nxt = DIV_CMP;
         DIV_CMP: state_nxt = DIV_CNT;
         DIV_CNT: begin
            if (cnt_last) begin
               fin       = ~neg;
               state_nxt = neg ? SIGN_Q : IDLE;
            end else begin
               state_nxt = DIV_R;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= IDLE;
         o_done <= 1'b0;
         ovf_r  <= 1'b0;
         zero_r <= 1'b0;
      end else begin
         state  <= state_nxt;
         o_done <= fin;
         ovf_r  <= fin_ovf;
         zero_r <= fin_zero;
      end
   end

   always_ff @(posedge i_clk) begin
      case (state)
         IDLE: begin
            if (i_start) begin
               tag_r  <= i_req.tag;
               neg    <= a_neg ^ b_neg;
               is_mul <= (i_req.op == OP_MUL);
               a      <= a_neg ? add_q : i_req.a;
               b      <= (b_neg & ~a_neg) ? add_q : i_req.b;   // both negative waits for SIGN_B.
               r      <= '0;
               cnt    <= '0;
               q      <= (i_req.op inside {OP_ADD, OP_SUB}) ? add_q : '0;
            end
         end
         SIGN_B: b <= add_q;
         SIGN_Q: q <= add_q;
         MUL: begin
            a <= a >> 1;
            b <= b << 1;
            if (a[0]) q <= add_q;
         end
         DIV_R: begin
            r <= {r[MSB-1:0], a[MSB]};
            a <= a << 1;
         end
         DIV_CMP: begin
            if (q_bit) r <= add_q;   // restore by keeping the old value.
            q <= {q[MSB-1:0], q_bit};
         end
         DIV_CNT: cnt <= add_q[CNT_W-1:0];
         default: ;
      endcase
   end

   assign o_rsp = '{tag: tag_r, q: q, ovf: ovf_r, zero: zero_r};

endmodule

`default_nettype wire

// File: op_dispatch.sv
`default_nettype none
`timescale 1ns/100ps
`include "alu_defs.svh"

module op_dispatch
   import alu_pkg::*;
(
   input  wire             i_clk,
   input  wire             i_nrst,
   input  wire             i_req,
   input  wire alu_req_t   i_req_data,
   input  wire lane_mask_t i_release,
   output logic            o_ready,
   output lane_mask_t      o_start,
   output alu_req_t        o_lane_req
);

   lane_mask_t busy;
   lane_mask_t pick;
   lane_mask_t issue;

   assign o_ready = ~&busy;
   assign issue   = i_req ? pick : '0;   // empty when all lanes busy.

   // lowest free lane wins.
   always_comb begin
      pick = '0;
      for (int i = `ALU_NUM_LANES - 1; i >= 0; i--) begin
         if (!busy[i]) pick = lane_mask_t'(1) << i;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy    <= '0;
         o_start <= '0;
      end else begin
         busy    <= (busy | issue) & ~i_release;
         o_start <= issue;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_req) o_lane_req <= i_req_data;
   end

endmodule

`default_nettype wire

// File: result_collect.sv
`default_nettype none
`timescale 1ns/100ps
`include "alu_defs.svh"

module result_collect
   import alu_pkg::*;
(
   input  wire             i_clk,
   input  wire             i_nrst,
   input  wire lane_mask_t i_done,
   input  wire alu_rsp_t   i_rsp [`ALU_NUM_LANES],
   output lane_mask_t      o_release,
   output logic            o_rsp_valid,
   output alu_rsp_t        o_rsp_data
);

   localparam int IDX_W = $clog2(`ALU_NUM_LANES);

   alu_rsp_t         hold [`ALU_NUM_LANES];
   lane_mask_t       pend;
   logic [IDX_W-1:0] ptr;
   logic [IDX_W-1:0] sel;
   logic [IDX_W-1:0] scan;

   // first pending lane at or after the pointer.
   always_comb begin
      sel  = ptr;
      scan = ptr;
      for (int k = `ALU_NUM_LANES - 1; k >= 0; k--) begin
         scan = ptr + IDX_W'(k);
         if (pend[scan]) sel = scan;
      end
   end

   assign o_rsp_valid = |pend;
   assign o_rsp_data  = hold[sel];
   assign o_release   = o_rsp_valid ? (lane_mask_t'(1) << sel) : '0;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         pend <= '0;
         ptr  <= '0;
      end else begin
         pend <= (pend & ~o_release) | i_done;
         if (o_rsp_valid) ptr <= sel + 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      for (int l = 0; l < `ALU_NUM_LANES; l++) begin
         if (i_done[l]) hold[l] <= i_rsp[l];
      end
   end

endmodule

`default_nettype wire

// File: alu_cluster.sv
`default_nettype none
`timescale 1ns/100ps
`include "alu_defs.svh"

module alu_cluster
   import alu_pkg::*;
(
   input  wire           i_clk,
   input  wire           i_nrst,
   input  wire           i_req,
   input  wire alu_req_t i_req_data,
   output logic          o_ready,
   output logic          o_rsp_valid,
   output alu_rsp_t      o_rsp_data
);

   wire lane_mask_t lane_start;
   wire lane_mask_t lane_done;
   wire lane_mask_t lane_free;
   wire alu_req_t   lane_req;
   wire alu_rsp_t   lane_rsp [`ALU_NUM_LANES];

   op_dispatch dispatch_inst (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_req      (i_req),
      .i_req_data (i_req_data),
      .i_release  (lane_free),
      .o_ready    (o_ready),
      .o_start    (lane_start),
      .o_lane_req (lane_req)
   );

   for (genvar g = 0; g < `ALU_NUM_LANES; g++) begin : g_lane
      seq_alu lane_inst (
         .i_clk   (i_clk),
         .i_nrst  (i_nrst),
         .i_start (lane_start[g]),
         .i_req   (lane_req),   // shared, only the started lane latches it.
         .o_done  (lane_done[g]),
         .o_rsp   (lane_rsp[g])
      );
   end

   result_collect collect_inst (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_done      (lane_done),
      .i_rsp       (lane_rsp),
      .o_release   (lane_free),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp_data  (o_rsp_data)
   );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clkgen #(
   parameter real PERIOD       = 4.0,
   parameter int  RESET_CYCLES = 4
) (
   output logic o_clk,
   output logic o_nrst
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD / 2.0) o_clk = ~o_clk;
   end

   initial begin
      o_nrst = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_nrst = 1'b1;   // release on the falling edge.
   end

endmodule

`default_nettype wire

// File: alu_cluster_checker.sv
`default_nettype none
`timescale 1ns/100ps
`include "alu_defs.svh"

module alu_cluster_checker
   import alu_pkg::*;
(
   input wire             i_clk,
   input wire             i_nrst,
   input wire             i_req,
   input wire             i_ready,
   input wire             i_rsp_valid,
   input wire lane_mask_t i_start
);

   int fail_count = 0;

   assert property (@(posedge i_clk) disable iff (!i_nrst) i_req |-> i_ready)
      else begin
         $error("request strobe while o_ready is low");
         fail_count++;
      end

   assert property (@(posedge i_clk) disable iff (!i_nrst) $onehot0(i_start))
      else begin
         $error("more than one lane started in a cycle");
         fail_count++;
      end

   // no result may leave while in reset or right after it.
   assert property (@(posedge i_clk) !i_nrst |-> !i_rsp_valid)
      else begin
         $error("o_rsp_valid high during reset");
         fail_count++;
      end

   assert property (@(posedge i_clk) $rose(i_nrst) |-> !i_rsp_valid)
      else begin
         $error("o_rsp_valid high in the first cycle after reset");
         fail_count++;
      end

endmodule

`default_nettype wire

// File: alu_monitor.sv
`default_nettype none
`timescale 1ns/100ps
`include "alu_defs.svh"

module alu_monitor
   import alu_pkg::*;
(
   input  wire           i_clk,
   input  wire           i_nrst,
   input  wire           i_req,
   input  wire alu_req_t i_req_data,
   input  wire           i_ready,
   input  wire           i_rsp_valid,
   input  wire alu_rsp_t i_rsp_data,
   output int            o_checks,
   output int            o_errors
);

   localparam int     W     = `ALU_DATA_WIDTH;
   localparam int     LANES = `ALU_NUM_LANES;
   localparam int     NTAG  = 1 << `ALU_TAG_WIDTH;
   localparam longint HI    = (64'sd1 <<< (W - 1)) - 1;
   localparam longint LO    = -HI - 1;

   alu_rsp_t exp_tab [NTAG];
   bit       pending [NTAG];
   int       busy_lanes;   // issued and not yet emitted.

   function automatic alu_rsp_t expected_rsp(input alu_req_t r);
      longint   sa;
      longint   sb;
      longint   res;
      alu_rsp_t e;
      sa     = r.a;
      sb     = r.b;
      res    = 0;
      e.tag  = r.tag;
      e.ovf  = 1'b0;
      e.zero = 1'b0;
      case (r.op)
         OP_ADD: begin
            res   = sa + sb;
            e.ovf = (res > HI) || (res < LO);
         end
         OP_SUB: begin
            res   = sa - sb;
            e.ovf = (res > HI) || (res < LO);
         end
         OP_MUL: begin
            res   = sa * sb;
            // the magnitude has to fit, so the most negative product overflows too.
            e.ovf = (sa == LO) || (sb == LO) || (res > HI) || (res < -HI);
         end
         default: begin
            if (sb == 0) begin
               e.ovf  = 1'b1;
               e.zero = 1'b1;
            end else begin
               e.ovf = (sa == LO) || (sb == LO);
               if (!e.ovf) res = sa / sb;   // truncates toward zero.
            end
         end
      endcase
      e.q = data_t'(res);
      return e;
   endfunction

   task automatic report_value(input string name, input longint got, input longint exp);
      $display("Fail %0t %s: got %0d, expected %0d", $time, name, got, exp);
      o_errors++;
   endtask

   task automatic compare(input alu_rsp_t got, input alu_rsp_t exp);
      string sfx;
      sfx = $sformatf(" (tag %0d)", got.tag);
      if (got.ovf !== exp.ovf) report_value({"o_rsp_data.ovf", sfx}, got.ovf, exp.ovf);
      if (got.zero !== exp.zero) report_value({"o_rsp_data.zero", sfx}, got.zero, exp.zero);
      if (!exp.ovf && (got.q !== exp.q)) report_value({"o_rsp_data.q", sfx}, got.q, exp.q);
   endtask

   initial begin
      o_checks   = 0;
      o_errors   = 0;
      busy_lanes = 0;
      foreach (pending[i]) pending[i] = 1'b0;
   end

   // falling edge, where requests and responses are settled.
   always @(negedge i_clk) begin
      if (i_nrst && (i_ready !== (busy_lanes < LANES))) begin
         report_value("o_ready", i_ready, busy_lanes < LANES);
      end
      if (i_nrst && i_rsp_valid) begin
         if (!pending[i_rsp_data.tag]) begin
            $display("response with tag %0d arrived with no request outstanding, at %0t",
                     i_rsp_data.tag, $time);
            o_errors++;
         end else begin
            compare(i_rsp_data, exp_tab[i_rsp_data.tag]);
            pending[i_rsp_data.tag] = 1'b0;
            o_checks++;
         end
      end
      if (i_nrst && i_req && i_ready) begin
         if (pending[i_req_data.tag]) begin
            $display("tag %0d was reused before its response arrived, at %0t",
                     i_req_data.tag, $time);
            o_errors++;
         end
         exp_tab[i_req_data.tag] = expected_rsp(i_req_data);
         pending[i_req_data.tag] = 1'b1;
      end
      if (i_nrst) begin
         busy_lanes = busy_lanes + int'(i_req && i_ready) - int'(i_rsp_valid);
      end
   end

endmodule

`default_nettype wire

// File: alu_cluster_tb.sv
`default_nettype none
`timescale 1ns/100ps
`include "alu_defs.svh"

module alu_cluster_tb
   import alu_pkg::*;
();

   localparam int    W     = `ALU_DATA_WIDTH;
   localparam int    LANES = `ALU_NUM_LANES;
   localparam int    NTAG  = 1 << `ALU_TAG_WIDTH;
   localparam int    N_REQ = 368;   // sum over the five tests.
   localparam int    LIMIT = N_REQ * (3 * W + 10) + 200;
   localparam data_t D_MAX = {1'b0, {(W-1){1'b1}}};
   localparam data_t D_MIN = {1'b1, {(W-1){1'b0}}};

   logic     clk;
   logic     nrst;
   logic     req;
   alu_req_t req_data;
   logic     ready;
   logic     rsp_valid;
   alu_rsp_t rsp_data;
   int       mon_checks;
   int       mon_errors;
   int       tb_errors;
   integer   seed;
   tag_t     tag_next;
   bit       tag_out [NTAG];
   int       in_flight;
   int       lanes_next;     // busy lanes in the coming cycle.
   int       sent;
   int       stall_cycles;
   int       stall_mark;
   int       sent_mark;
   int       check_mark;
   int       error_mark;
   int       cycles;
   data_t    vals [$];

   tb_clkgen clkgen_inst (
      .o_clk  (clk),
      .o_nrst (nrst)
   );

   alu_cluster alu_cluster_inst (
      .i_clk       (clk),
      .i_nrst      (nrst),
      .i_req       (req),
      .i_req_data  (req_data),
      .o_ready     (ready),
      .o_rsp_valid (rsp_valid),
      .o_rsp_data  (rsp_data)
   );

   alu_monitor monitor_inst (
      .i_clk       (clk),
      .i_nrst      (nrst),
      .i_req       (req),
      .i_req_data  (req_data),
      .i_ready     (ready),
      .i_rsp_valid (rsp_valid),
      .i_rsp_data  (rsp_data),
      .o_checks    (mon_checks),
      .o_errors    (mon_errors)
   );

   bind alu_cluster alu_cluster_checker checker_inst (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_req       (i_req),
      .i_ready     (o_ready),
      .i_rsp_valid (o_rsp_valid),
      .i_start     (lane_start)
   );

   function automatic int total_errors();
      return mon_errors + tb_errors + alu_cluster_inst.checker_inst.fail_count;
   endfunction

   // a lane is taken by a request and freed by each emitted result.
   always @(negedge clk) begin
      if (nrst) begin
         lanes_next = lanes_next + int'(req) - int'(rsp_valid);
         if (!ready) stall_cycles++;
         if (rsp_valid && tag_out[rsp_data.tag]) begin
            tag_out[rsp_data.tag] = 1'b0;
            in_flight--;
         end
      end
   end

   task automatic send(input op_e op, input data_t a, input data_t b);
      @(posedge clk);
      while (lanes_next >= LANES || tag_out[tag_next]) begin
         req <= 1'b0;
         @(posedge clk);
      end
      req      <= 1'b1;
      req_data <= '{op: op, tag: tag_next, a: a, b: b};
      tag_out[tag_next] = 1'b1;
      tag_next = tag_next + 1'b1;
      in_flight++;
      sent++;
   endtask

   task automatic sweep(input op_e op);
      foreach (vals[i]) begin
         foreach (vals[j]) send(op, vals[i], vals[j]);
      end
   endtask

   task automatic begin_test();
      sent_mark  = sent;
      check_mark = mon_checks;
      error_mark = total_errors();
   endtask

   task automatic end_test(input string name);
      @(posedge clk);
      req <= 1'b0;
      while (in_flight != 0) @(posedge clk);
      $display("%-30s %0d requests, %0d responses, %0d errors", name, sent - sent_mark,
               mon_checks - check_mark, total_errors() - error_mark);
   endtask

   initial begin
      seed         = 4;
      req          = 1'b0;
      req_data     = '0;
      tag_next     = '0;
      in_flight    = 0;
      lanes_next   = 0;
      sent         = 0;
      tb_errors    = 0;
      stall_cycles = 0;
      foreach (tag_out[i]) tag_out[i] = 1'b0;
      @(posedge nrst);

      begin_test();
      vals = '{data_t'(0), data_t'(1), data_t'(-1), D_MAX, D_MIN};
      sweep(OP_ADD);
      sweep(OP_SUB);
      repeat (30) send(($random(seed) & 1) ? OP_SUB : OP_ADD, data_t'($random(seed)),
                       data_t'($random(seed)));
      end_test("test 1 add and subtract");

      begin_test();
      vals = '{data_t'(0), data_t'(1), data_t'(-1), data_t'(3), data_t'(-5), data_t'(181),
               data_t'(-181), data_t'(256), D_MAX, D_MIN};
      sweep(OP_MUL);
      repeat (20) send(OP_MUL, data_t'($random(seed) % 200), data_t'($random(seed) % 200));
      end_test("test 2 multiply");

      begin_test();
      vals = '{data_t'(0), data_t'(1), data_t'(-1), data_t'(7), data_t'(-7), data_t'(100),
               data_t'(-300), D_MAX, D_MIN};
      sweep(OP_DIV);
      end_test("test 3 divide");

      begin_test();
      stall_mark = stall_cycles;
      repeat (48) send(op_e'($random(seed) & 3), data_t'($random(seed)),
                       data_t'($random(seed) % 300));
      if (stall_cycles == stall_mark) begin
         $display("o_ready never went low during the burst");
         tb_errors++;
      end
      end_test("test 4 full rate burst");

      begin_test();
      repeat (3) begin
         repeat (3) send(OP_DIV, data_t'($random(seed)), data_t'($random(seed) % 50 + 1));
         repeat (10) send(OP_ADD, data_t'($random(seed)), data_t'($random(seed)));
      end
      end_test("test 5 adds between divides");

      $display("%0d requests, %0d responses checked, %0d errors", sent, mon_checks,
               total_errors());
      if (mon_checks != sent) $display("the number of responses does not match the requests");
      if (total_errors() == 0 && mon_checks == sent) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin
      cycles = 0;
      while (cycles < LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, a response never arrived", cycles);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: alu_cluster.f
+incdir+.
alu_pkg.sv
sat_adder.sv
seq_alu.sv
op_dispatch.sv
result_collect.sv
alu_cluster.sv
tb_clkgen.sv
alu_cluster_checker.sv
alu_monitor.sv
alu_cluster_tb.sv
